// ==== testbench/corePatterns.txt ====
// inst memRdata expPc expMemWe expMemAddr expMemWdata expMemWmask expHalt
// First value is the number of pattern lines that follow
00000043
ffb00093 00000000 80000000 0 00000000 00000000 0 0 // addi x1, x0, -5
00300113 00000000 80000004 0 00000000 00000000 0 0 // addi x2, x0, 3
4020d1b3 00000000 80000008 0 00000000 00000000 0 0 // sra x3, x1, x2
10302023 00000000 8000000c 1 00000100 ffffffff f 0 // sw x3, 0x100(x0)
0020d233 00000000 80000010 0 00000000 00000000 0 0 // srl x4, x1, x2
10402223 00000000 80000014 1 00000104 1fffffff f 0 // sw x4, 0x104(x0)
0020a2b3 00000000 80000018 0 00000000 00000000 0 0 // slt x5, x1, x2
0020b333 00000000 8000001c 0 00000000 00000000 0 0 // sltu x6, x1, x2
10502423 00000000 80000020 1 00000108 00000001 f 0 // sw x5, 0x108(x0)
10602623 00000000 80000024 1 0000010c 00000000 f 0 // sw x6, 0x10c(x0)
123453b7 00000000 80000028 0 00000000 00000000 0 0 // lui x7, 0x12345
67838393 00000000 8000002c 0 00000000 00000000 0 0 // addi x7, x7, 0x678
00001417 00000000 80000030 0 00000000 00000000 0 0 // auipc x8, 0x1
fff3c493 00000000 80000034 0 00000000 00000000 0 0 // xori x9, x7, -1
10702823 00000000 80000038 1 00000110 12345678 f 0 // sw x7, 0x110(x0)
10802a23 00000000 8000003c 1 00000114 80001030 f 0 // sw x8, 0x114(x0)
10902c23 00000000 80000040 1 00000118 edcba987 f 0 // sw x9, 0x118(x0)
00708013 00000000 80000044 0 00000000 00000000 0 0 // addi x0, x1, 7
10002e23 00000000 80000048 1 0000011c 00000000 f 0 // sw x0, 0x11c(x0)
40110533 00000000 8000004c 0 00000000 00000000 0 0 // sub x10, x2, x1
00451593 00000000 80000050 0 00000000 00000000 0 0 // slli x11, x10, 4
0075e633 00000000 80000054 0 00000000 00000000 0 0 // or x12, x11, x7
0ff67693 00000000 80000058 0 00000000 00000000 0 0 // andi x13, x12, 0xff
12d02023 00000000 8000005c 1 00000120 000000f8 f 0 // sw x13, 0x120(x0)
00208463 00000000 80000060 0 00000000 00000000 0 0 // beq x1, x2, +8 not taken
00209463 00000000 80000064 0 00000000 00000000 0 0 // bne x1, x2, +8 taken
0020c463 00000000 8000006c 0 00000000 00000000 0 0 // blt x1, x2, +8 taken
0020d463 00000000 80000074 0 00000000 00000000 0 0 // bge x1, x2, +8 not taken
0020e463 00000000 80000078 0 00000000 00000000 0 0 // bltu x1, x2, +8 not taken
0020f463 00000000 8000007c 0 00000000 00000000 0 0 // bgeu x1, x2, +8 taken
00210463 00000000 80000084 0 00000000 00000000 0 0 // beq x2, x2, +8 taken
00211463 00000000 8000008c 0 00000000 00000000 0 0 // bne x2, x2, +8 not taken
00114463 00000000 80000090 0 00000000 00000000 0 0 // blt x2, x1, +8 not taken
00115463 00000000 80000094 0 00000000 00000000 0 0 // bge x2, x1, +8 taken
00116463 00000000 8000009c 0 00000000 00000000 0 0 // bltu x2, x1, +8 taken
00117463 00000000 800000a4 0 00000000 00000000 0 0 // bgeu x2, x1, +8 not taken
0100076f 00000000 800000a8 0 00000000 00000000 0 0 // jal x14, +16
01d707e7 00000000 800000b8 0 00000000 00000000 0 0 // jalr x15, 0x1d(x14)
12e02223 00000000 800000c8 1 00000124 800000ac f 0 // sw x14, 0x124(x0)
12f02423 00000000 800000cc 1 00000128 800000bc f 0 // sw x15, 0x128(x0)
20000803 7b8c9a3e 800000d0 0 00000000 00000000 0 0 // lb x16, 0x200(x0)
13002823 00000000 800000d4 1 00000130 0000003e f 0 // sw x16, 0x130(x0)
20100803 7b8c9a3e 800000d8 0 00000000 00000000 0 0 // lb x16, 0x201(x0)
13002823 00000000 800000dc 1 00000130 ffffff9a f 0 // sw x16, 0x130(x0)
20200803 7b8c9a3e 800000e0 0 00000000 00000000 0 0 // lb x16, 0x202(x0)
13002823 00000000 800000e4 1 00000130 ffffff8c f 0 // sw x16, 0x130(x0)
20300803 7b8c9a3e 800000e8 0 00000000 00000000 0 0 // lb x16, 0x203(x0)
13002823 00000000 800000ec 1 00000130 0000007b f 0 // sw x16, 0x130(x0)
20104803 7b8c9a3e 800000f0 0 00000000 00000000 0 0 // lbu x16, 0x201(x0)
13002823 00000000 800000f4 1 00000130 0000009a f 0 // sw x16, 0x130(x0)
20204803 7b8c9a3e 800000f8 0 00000000 00000000 0 0 // lbu x16, 0x202(x0)
13002823 00000000 800000fc 1 00000130 0000008c f 0 // sw x16, 0x130(x0)
20001803 7b8c9a3e 80000100 0 00000000 00000000 0 0 // lh x16, 0x200(x0)
13002823 00000000 80000104 1 00000130 ffff9a3e f 0 // sw x16, 0x130(x0)
20201803 7b8c9a3e 80000108 0 00000000 00000000 0 0 // lh x16, 0x202(x0)
13002823 00000000 8000010c 1 00000130 00007b8c f 0 // sw x16, 0x130(x0)
20005803 7b8c9a3e 80000110 0 00000000 00000000 0 0 // lhu x16, 0x200(x0)
13002823 00000000 80000114 1 00000130 00009a3e f 0 // sw x16, 0x130(x0)
20402803 5a6b7c8d 80000118 0 00000000 00000000 0 0 // lw x16, 0x204(x0)
13002823 00000000 8000011c 1 00000130 5a6b7c8d f 0 // sw x16, 0x130(x0)
147000a3 00000000 80000120 1 00000141 78787878 2 0 // sb x7, 0x141(x0)
147001a3 00000000 80000124 1 00000143 78787878 8 0 // sb x7, 0x143(x0)
14701023 00000000 80000128 1 00000140 56785678 3 0 // sh x7, 0x140(x0)
14701123 00000000 8000012c 1 00000142 56785678 c 0 // sh x7, 0x142(x0)
00100073 00000000 80000130 0 00000000 00000000 0 0 // ebreak
10702823 00000000 80000130 0 00000000 00000000 0 1 // sw x7 while halted
ffb00093 00000000 80000130 0 00000000 00000000 0 1 // addi x1 while halted

// ==== flist.f ====
logic/rvIsaPkg.sv
logic/coreCtrlPkg.sv
logic/instDecoder.sv
logic/regFile.sv
logic/executeUnit.sv
logic/resultUnit.sv
logic/coreTop.sv
testbench/coreTb.sv

// ==== Makefile ====
# Verilator build and run for the RV32I core testbench

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f --top-module coreTb
	@out=$$(./obj_dir/VcoreTb); echo "$$out"; echo "$$out" | grep -q "Verification passed"

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f flist.f --top-module coreTb

clean:
	rm -rf obj_dir

// ==== testbench/coreTb.sv ====
`timescale 1ns/1ps

module coreTb;

  localparam int clkPeriod   = 40;
  localparam int resetCycles = 8;
  localparam int maxLines    = 128;
  localparam int fieldCount  = 8;

  logic        clk;
  logic        rstN;
  logic [31:0] inst;
  logic [31:0] memRdata;
  logic [31:0] pc;
  logic        memWe;
  logic [31:0] memAddr;
  logic [31:0] memWdata;
  logic [3:0]  memWmask;
  logic        halt;

  // Word 0 is the line count, then eight words per line
  logic [31:0] patWords [0:maxLines*fieldCount];
  int          lineCount;
  bit          patternsLoaded;

  coreTop dut_i (
    .clk     (clk),
    .rstN    (rstN),
    .inst    (inst),
    .memRdata(memRdata),
    .pc      (pc),
    .memWe   (memWe),
    .memAddr (memAddr),
    .memWdata(memWdata),
    .memWmask(memWmask),
    .halt    (halt)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic compareField(input int line, input string name,
                              input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      abortRun($sformatf("Mismatch %s on line %0d: expected %h, got %h",
                         name, line, expected, actual));
    end
  endtask

  // Address and data only matter while a store is live
  task automatic checkLine(input int line, input int base);
    logic expWe;
    expWe = patWords[base+3][0];
    compareField(line, "pc", patWords[base+2], pc);
    compareField(line, "memWe", {31'b0, expWe}, {31'b0, memWe});
    if (expWe) begin
      compareField(line, "memAddr", patWords[base+4], memAddr);
      compareField(line, "memWdata", patWords[base+5], memWdata);
      compareField(line, "memWmask", patWords[base+6], {28'b0, memWmask});
    end
    compareField(line, "halt", patWords[base+7], {31'b0, halt});
  endtask

  initial begin
    wait (patternsLoaded);
    #((lineCount + resetCycles + 20) * clkPeriod);
    abortRun("Timeout: the pattern run did not finish in time");
  end

  initial begin
    int base;
    rstN     = 1'b0;
    inst     = '0;
    memRdata = '0;
    $readmemh("testbench/corePatterns.txt", patWords);
    lineCount = patWords[0];
    if (lineCount <= 0 || lineCount > maxLines) begin
      abortRun("Pattern file is missing or gives a bad line count");
    end
    patternsLoaded = 1'b1;

    repeat (resetCycles) @(posedge clk);
    #2;
    rstN = 1'b1;

    for (int i = 0; i < lineCount; i++) begin
      base     = 1 + i * fieldCount;
      inst     = patWords[base];
      memRdata = patWords[base+1];
      // Sample just before the committing edge
      #(clkPeriod - 4);
      checkLine(i, base);
      @(posedge clk);
      #2;
    end

    $display("Verification passed");
    $finish;
  end

endmodule

// ==== logic/coreTop.sv ====
`timescale 1ns/1ps

module coreTop #(
  parameter int          xlen        = 32,
  parameter logic [31:0] resetVector = 32'h80000000
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic [31:0]     inst,
  input  logic [xlen-1:0] memRdata,
  output logic [xlen-1:0] pc,
  output logic            memWe,
  output logic [xlen-1:0] memAddr,
  output logic [xlen-1:0] memWdata,
  output logic [3:0]      memWmask,
  output logic            halt
);

  logic [rvIsaPkg::regIdxW-1:0] rs1;
  logic [rvIsaPkg::regIdxW-1:0] rs2;
  logic [rvIsaPkg::regIdxW-1:0] rd;
  logic [xlen-1:0]              imm;
  coreCtrlPkg::aluOpE           aluOp;
  coreCtrlPkg::aluASelE         aluASel;
  coreCtrlPkg::aluBSelE         aluBSel;
  coreCtrlPkg::pcSelE           pcSel;
  rvIsaPkg::branchF3E           brCond;
  coreCtrlPkg::wbSelE           wbSel;
  rvIsaPkg::memF3E              memSize;
  logic                         decRegWe;
  logic                         decMemWe;
  logic                         isEbreak;
  logic [xlen-1:0]              rdata1;
  logic [xlen-1:0]              rdata2;
  logic [xlen-1:0]              aluOut;
  logic [xlen-1:0]              nextPc;
  logic [xlen-1:0]              pcPlus4;
  logic [xlen-1:0]              wbData;

  // PC holds from the EBREAK onward
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc   <= resetVector;
      halt <= 1'b0;
    end else begin
      if (!halt && !isEbreak) pc <= nextPc;
      if (isEbreak) halt <= 1'b1;
    end
  end

  assign pcPlus4 = pc + xlen'(4);
  assign memWe   = decMemWe & ~halt;
  assign memAddr = aluOut;

  instDecoder #(.xlen(xlen)) decoder_i (
    .inst    (inst),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .imm     (imm),
    .aluOp   (aluOp),
    .aluASel (aluASel),
    .aluBSel (aluBSel),
    .pcSel   (pcSel),
    .brCond  (brCond),
    .wbSel   (wbSel),
    .regWe   (decRegWe),
    .memWe   (decMemWe),
    .memSize (memSize),
    .isEbreak(isEbreak)
  );

  regFile regFile_i (
    .clk   (clk),
    .rstN  (rstN),
    .raddr1(rs1),
    .raddr2(rs2),
    .waddr (rd),
    .wdata (wbData),
    .we    (decRegWe & ~halt),
    .rdata1(rdata1),
    .rdata2(rdata2)
  );

  executeUnit #(.xlen(xlen)) execute_i (
    .pc     (pc),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .imm    (imm),
    .aluOp  (aluOp),
    .aluASel(aluASel),
    .aluBSel(aluBSel),
    .pcSel  (pcSel),
    .brCond (brCond),
    .aluOut (aluOut),
    .nextPc (nextPc)
  );

  resultUnit #(.xlen(xlen)) result_i (
    .aluOut  (aluOut),
    .rdata2  (rdata2),
    .memRdata(memRdata),
    .pcPlus4 (pcPlus4),
    .memSize (memSize),
    .wbSel   (wbSel),
    .memWdata(memWdata),
    .memWmask(memWmask),
    .wbData  (wbData)
  );

endmodule

// ==== logic/resultUnit.sv ====
`timescale 1ns/1ps

module resultUnit #(
  parameter int xlen = 32
) (
  input  logic [xlen-1:0]    aluOut,
  input  logic [xlen-1:0]    rdata2,
  input  logic [xlen-1:0]    memRdata,
  input  logic [xlen-1:0]    pcPlus4,
  input  rvIsaPkg::memF3E    memSize,
  input  coreCtrlPkg::wbSelE wbSel,
  output logic [xlen-1:0]    memWdata,
  output logic [3:0]         memWmask,
  output logic [xlen-1:0]    wbData
);

  logic [1:0]      offset;
  logic [xlen-1:0] shifted;
  logic [15:0]     halfLane;
  logic [xlen-1:0] loadData;

  assign offset = aluOut[1:0];

  // Stores: data in every lane, mask picks the live ones
  always_comb begin
    case (memSize)
      rvIsaPkg::memByte: begin
        memWdata = {4{rdata2[7:0]}};
        memWmask = 4'b0001 << offset;
      end
      rvIsaPkg::memHalf: begin
        memWdata = {2{rdata2[15:0]}};
        memWmask = offset[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        memWdata = rdata2;
        memWmask = 4'b1111;
      end
    endcase
  end

  // Loads
  assign shifted  = memRdata >> {offset, 3'b000};
  assign halfLane = offset[1] ? memRdata[31:16] : memRdata[15:0];

  always_comb begin
    case (memSize)
      rvIsaPkg::memByte:  loadData = {{(xlen-8){shifted[7]}}, shifted[7:0]};
      rvIsaPkg::memHalf:  loadData = {{(xlen-16){halfLane[15]}}, halfLane};
      rvIsaPkg::memByteU: loadData = {{(xlen-8){1'b0}}, shifted[7:0]};
      rvIsaPkg::memHalfU: loadData = {{(xlen-16){1'b0}}, halfLane};
      default:            loadData = memRdata;
    endcase
  end

  always_comb begin
    case (wbSel)
      coreCtrlPkg::wbMem: wbData = loadData;
      coreCtrlPkg::wbPc4: wbData = pcPlus4;
      default:            wbData = aluOut;
    endcase
  end

endmodule

// ==== logic/executeUnit.sv ====
`timescale 1ns/1ps

module executeUnit #(
  parameter int xlen = 32
) (
  input  logic [xlen-1:0]      pc,
  input  logic [xlen-1:0]      rdata1,
  input  logic [xlen-1:0]      rdata2,
  input  logic [xlen-1:0]      imm,
  input  coreCtrlPkg::aluOpE   aluOp,
  input  coreCtrlPkg::aluASelE aluASel,
  input  coreCtrlPkg::aluBSelE aluBSel,
  input  coreCtrlPkg::pcSelE   pcSel,
  input  rvIsaPkg::branchF3E   brCond,
  output logic [xlen-1:0]      aluOut,
  output logic [xlen-1:0]      nextPc
);

  logic [xlen-1:0] opA;
  logic [xlen-1:0] opB;
  logic [4:0]      shamt;
  logic [xlen-1:0] pcPlus4;
  logic            takesBranch;

  assign opA   = (aluASel == coreCtrlPkg::aluAPc) ? pc : rdata1;
  assign opB   = (aluBSel == coreCtrlPkg::aluBImm) ? imm : rdata2;
  assign shamt = opB[4:0];

  always_comb begin
    case (aluOp)
      coreCtrlPkg::aluSub:   aluOut = opA - opB;
      coreCtrlPkg::aluSll:   aluOut = opA << shamt;
      coreCtrlPkg::aluSlt:   aluOut = {{(xlen-1){1'b0}}, $signed(opA) < $signed(opB)};
      coreCtrlPkg::aluSltu:  aluOut = {{(xlen-1){1'b0}}, opA < opB};
      coreCtrlPkg::aluXor:   aluOut = opA ^ opB;
      coreCtrlPkg::aluSrl:   aluOut = opA >> shamt;
      coreCtrlPkg::aluSra:   aluOut = $signed(opA) >>> shamt;
      coreCtrlPkg::aluOr:    aluOut = opA | opB;
      coreCtrlPkg::aluAnd:   aluOut = opA & opB;
      coreCtrlPkg::aluPassB: aluOut = opB;
      default:               aluOut = opA + opB;
    endcase
  end

  // Branch compare works on the register values, not the ALU operands
  always_comb begin
    case (brCond)
      rvIsaPkg::brEq:  takesBranch = (rdata1 == rdata2);
      rvIsaPkg::brNe:  takesBranch = (rdata1 != rdata2);
      rvIsaPkg::brLt:  takesBranch = ($signed(rdata1) < $signed(rdata2));
      rvIsaPkg::brGe:  takesBranch = ($signed(rdata1) >= $signed(rdata2));
      rvIsaPkg::brLtu: takesBranch = (rdata1 < rdata2);
      rvIsaPkg::brGeu: takesBranch = (rdata1 >= rdata2);
      default:         takesBranch = 1'b0;
    endcase
  end

  assign pcPlus4 = pc + xlen'(4);

  always_comb begin
    case (pcSel)
      // Bit 0 cleared for JALR; JAL targets are even anyway
      coreCtrlPkg::pcJump:   nextPc = {aluOut[xlen-1:1], 1'b0};
      coreCtrlPkg::pcBranch: nextPc = takesBranch ? aluOut : pcPlus4;
      default:               nextPc = pcPlus4;
    endcase
  end

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/1ps

module regFile (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic [rvIsaPkg::regIdxW-1:0] raddr1,
  input  logic [rvIsaPkg::regIdxW-1:0] raddr2,
  input  logic [rvIsaPkg::regIdxW-1:0] waddr,
  input  logic [31:0]                  wdata,
  input  logic                         we,
  output logic [31:0]                  rdata1,
  output logic [31:0]                  rdata2
);

  // x0 has no storage
  logic [31:0] regs [1:31];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== logic/instDecoder.sv ====
`timescale 1ns/1ps

module instDecoder #(
  parameter int xlen = 32
) (
  input  logic [31:0]                   inst,
  output logic [rvIsaPkg::regIdxW-1:0]  rs1,
  output logic [rvIsaPkg::regIdxW-1:0]  rs2,
  output logic [rvIsaPkg::regIdxW-1:0]  rd,
  output logic [xlen-1:0]               imm,
  output coreCtrlPkg::aluOpE            aluOp,
  output coreCtrlPkg::aluASelE          aluASel,
  output coreCtrlPkg::aluBSelE          aluBSel,
  output coreCtrlPkg::pcSelE            pcSel,
  output rvIsaPkg::branchF3E            brCond,
  output coreCtrlPkg::wbSelE            wbSel,
  output logic                          regWe,
  output logic                          memWe,
  output rvIsaPkg::memF3E               memSize,
  output logic                          isEbreak
);

  rvIsaPkg::opcodeE             opcode;
  logic [rvIsaPkg::funct3W-1:0] funct3;
  logic [rvIsaPkg::funct7W-1:0] funct7;
  logic [xlen-1:0]              immI;
  logic [xlen-1:0]              immS;
  logic [xlen-1:0]              immB;
  logic [xlen-1:0]              immU;
  logic [xlen-1:0]              immJ;
  coreCtrlPkg::aluOpE           aluFunc;

  assign opcode = rvIsaPkg::opcodeE'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];
  assign rd  = inst[11:7];

  assign brCond  = rvIsaPkg::branchF3E'(funct3);
  assign memSize = rvIsaPkg::memF3E'(funct3);

  // Immediate formats, all sign-extended from inst[31]
  assign immI = {{(xlen-12){inst[31]}}, inst[31:20]};
  assign immS = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{(xlen-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {inst[31:12], 12'b0};
  assign immJ = {{(xlen-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // funct3/funct7 to ALU op; SUB exists only in register form
  always_comb begin
    case (funct3)
      3'b000: begin
        if (opcode == rvIsaPkg::opOp && funct7[5]) aluFunc = coreCtrlPkg::aluSub;
        else aluFunc = coreCtrlPkg::aluAdd;
      end
      3'b001: aluFunc = coreCtrlPkg::aluSll;
      3'b010: aluFunc = coreCtrlPkg::aluSlt;
      3'b011: aluFunc = coreCtrlPkg::aluSltu;
      3'b100: aluFunc = coreCtrlPkg::aluXor;
      3'b101: aluFunc = funct7[5] ? coreCtrlPkg::aluSra : coreCtrlPkg::aluSrl;
      3'b110: aluFunc = coreCtrlPkg::aluOr;
      default: aluFunc = coreCtrlPkg::aluAnd;
    endcase
  end

  always_comb begin
    // Defaults describe a no-op
    imm      = immI;
    aluOp    = coreCtrlPkg::aluAdd;
    aluASel  = coreCtrlPkg::aluAReg;
    aluBSel  = coreCtrlPkg::aluBImm;
    pcSel    = coreCtrlPkg::pcPlus4;
    wbSel    = coreCtrlPkg::wbAlu;
    regWe    = 1'b0;
    memWe    = 1'b0;
    isEbreak = 1'b0;
    case (opcode)
      rvIsaPkg::opLui: begin
        imm   = immU;
        aluOp = coreCtrlPkg::aluPassB;
        regWe = 1'b1;
      end
      rvIsaPkg::opAuipc: begin
        imm     = immU;
        aluASel = coreCtrlPkg::aluAPc;
        regWe   = 1'b1;
      end
      rvIsaPkg::opJal: begin
        imm     = immJ;
        aluASel = coreCtrlPkg::aluAPc;
        pcSel   = coreCtrlPkg::pcJump;
        wbSel   = coreCtrlPkg::wbPc4;
        regWe   = 1'b1;
      end
      rvIsaPkg::opJalr: begin
        pcSel = coreCtrlPkg::pcJump;
        wbSel = coreCtrlPkg::wbPc4;
        regWe = 1'b1;
      end
      rvIsaPkg::opBranch: begin
        // ALU forms the target, compare happens beside it
        imm     = immB;
        aluASel = coreCtrlPkg::aluAPc;
        pcSel   = coreCtrlPkg::pcBranch;
      end
      rvIsaPkg::opLoad: begin
        wbSel = coreCtrlPkg::wbMem;
        regWe = 1'b1;
      end
      rvIsaPkg::opStore: begin
        imm   = immS;
        memWe = 1'b1;
      end
      rvIsaPkg::opOpImm: begin
        aluOp = aluFunc;
        regWe = 1'b1;
      end
      rvIsaPkg::opOp: begin
        aluOp   = aluFunc;
        aluBSel = coreCtrlPkg::aluBReg;
        regWe   = 1'b1;
      end
      rvIsaPkg::opSystem: isEbreak = (inst == rvIsaPkg::ebreakWord);
      default: ;
    endcase
  end

endmodule

// ==== logic/coreCtrlPkg.sv ====
package coreCtrlPkg;

  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluSll,
    aluSlt,
    aluSltu,
    aluXor,
    aluSrl,
    aluSra,
    aluOr,
    aluAnd,
    aluPassB  // LUI, immediate straight through
  } aluOpE;

  typedef enum logic {
    aluAReg = 1'b0,
    aluAPc  = 1'b1
  } aluASelE;

  typedef enum logic {
    aluBReg = 1'b0,
    aluBImm = 1'b1
  } aluBSelE;

  // Writeback source
  typedef enum logic [1:0] {
    wbMem = 2'b00,
    wbAlu = 2'b01,
    wbPc4 = 2'b10
  } wbSelE;

  // Next PC source; pcBranch defers to the compare result
  typedef enum logic [1:0] {
    pcPlus4  = 2'b00,
    pcJump   = 2'b01,
    pcBranch = 2'b10
  } pcSelE;

endpackage

// ==== logic/rvIsaPkg.sv ====
package rvIsaPkg;

  // Instruction field widths
  localparam int opcodeW = 7;
  localparam int regIdxW = 5;
  localparam int funct3W = 3;
  localparam int funct7W = 7;

  // RV32I major opcodes, inst[6:0]
  typedef enum logic [opcodeW-1:0] {
    opLui    = 7'b0110111,
    opAuipc  = 7'b0010111,
    opJal    = 7'b1101111,
    opJalr   = 7'b1100111,
    opBranch = 7'b1100011,
    opLoad   = 7'b0000011,
    opStore  = 7'b0100011,
    opOpImm  = 7'b0010011,
    opOp     = 7'b0110011,
    opSystem = 7'b1110011
  } opcodeE;

  // Branch conditions in funct3
  typedef enum logic [funct3W-1:0] {
    brEq  = 3'b000,
    brNe  = 3'b001,
    brLt  = 3'b100,
    brGe  = 3'b101,
    brLtu = 3'b110,
    brGeu = 3'b111
  } branchF3E;

  // Load and store widths in funct3
  typedef enum logic [funct3W-1:0] {
    memByte  = 3'b000,
    memHalf  = 3'b001,
    memWord  = 3'b010,
    memByteU = 3'b100,
    memHalfU = 3'b101
  } memF3E;

  localparam logic [31:0] ebreakWord = 32'h00100073;

endpackage
